//--- verification/heapMemory_input.txt
# name action array index in(hex) expectedOut(hex) expectedError
# action and error are decimal codes from heapPkg, out holds its value on errors
allocFirst0 18 0 0 0000 0000 0
allocNext1 18 0 0 0000 0001 0
allocNext2 18 0 0 0000 0002 0
allocNext3 18 0 0 0000 0003 0
allocNext4 18 0 0 0000 0004 0
allocNext5 18 0 0 0000 0005 0
allocNext6 18 0 0 0000 0006 0
allocNext7 18 0 0 0000 0007 0
allocNoneLeft 18 0 0 0000 0007 7
clearAll 1 0 0 0000 0007 0
allocAfterClear 18 0 0 0000 0000 0
writeIndex5 2 0 5 abcd abcd 0
sizeAfterWrite 4 0 0 0000 0006 0
readIndex5 3 0 5 0000 abcd 0
readIndex6 3 0 6 0000 abcd 3
readUnallocated 3 5 0 0000 abcd 1
allocForFree 18 0 0 0000 0001 0
freeArray1 19 1 0 0000 0001 0
writeFreed 2 1 0 1234 0001 2
freeTwice 19 1 0 0000 0001 2
allocReuse1 18 0 0 0000 0001 0
push0 14 1 0 0011 0001 0
push1 14 1 0 0022 0001 0
push2 14 1 0 0033 0001 0
push3 14 1 0 0044 0001 0
push4 14 1 0 0055 0001 0
push5 14 1 0 0066 0001 0
push6 14 1 0 0077 0001 0
push7 14 1 0 0088 0001 0
pushFull 14 1 0 0099 0001 4
pop7 15 1 0 0000 0088 0
pop6 15 1 0 0000 0077 0
pop5 15 1 0 0000 0066 0
pop4 15 1 0 0000 0055 0
pop3 15 1 0 0000 0044 0
pop2 15 1 0 0000 0033 0
pop1 15 1 0 0000 0022 0
pop0 15 1 0 0000 0011 0
popEmpty 15 1 0 0000 0011 5
resizeTo9 17 1 0 0009 0011 6
resizeTo3 17 1 0 0003 0011 0
sizeAfterResize 4 1 0 0000 0003 0
allocFresh2 18 0 0 0000 0002 0
allocFresh3 18 0 0 0000 0003 0
allocFresh4 18 0 0 0000 0004 0
free2 19 2 0 0000 0004 0
free4 19 4 0 0000 0004 0
allocGets4 18 0 0 0000 0004 0
sizeOf4 4 4 0 0000 0000 0
allocGets2 18 0 0 0000 0002 0
sizeOf2 4 2 0 0000 0000 0
writeArith 2 3 0 fff0 fff0 0
addWrap 20 3 0 0015 0005 0
subtractWrap 22 3 0 0009 fffc 0
addWrapAgain 20 3 0 1000 0ffc 0
orBits 28 3 0 3001 3ffd 0
xorBits 29 3 0 00ff 3f02 0
andBits 30 3 0 0f0f 0f02 0
readArith 3 3 0 0000 0f02 0
badAction 99 0 0 0000 0f02 8

//--- src.f
hdl/heapPkg.sv
hdl/arrayTable.sv
hdl/elementStore.sv
hdl/heapMemory.sv
verification/heapMemory_assertions.sv
verification/heapMemoryTb.sv

//--- Bender.yml
package:
  name: heap_memory

sources:
  - hdl/heapPkg.sv
  - hdl/arrayTable.sv
  - hdl/elementStore.sv
  - hdl/heapMemory.sv
  - target: simulation
    files:
      - verification/heapMemory_assertions.sv
      - verification/heapMemoryTb.sv

//--- verification/heapMemoryTb.sv
/*
  Testbench for the array heap
  Replays requests from a data file and checks out and error at each done
*/
module heapMemoryTb;
  import heapPkg::*;

  localparam string InputFile = "verification/heapMemory_input.txt";
  localparam int    MaxTests  = 256;                  // Room in the request table

  logic                   clock;
  logic                   resetN;
  logic                   request;
  action_t                action;
  logic [AddressBits-1:0] array;
  logic [IndexBits-1:0]   index;
  logic [DataBits-1:0]    in;
  logic                   done;
  logic [DataBits-1:0]    out;
  heapError_t             error;

  //----------------------------------------------------------------------
  // Request table loaded from the data file
  //----------------------------------------------------------------------
  string                  testName   [MaxTests];
  logic [7:0]             testAction [MaxTests];
  logic [AddressBits-1:0] testArray  [MaxTests];
  logic [IndexBits-1:0]   testIndex  [MaxTests];
  logic [DataBits-1:0]    testIn     [MaxTests];
  logic [DataBits-1:0]    testOut    [MaxTests];    // Expected out at done
  logic [3:0]             testError  [MaxTests];    // Expected error code

  int testCount    = 0;
  int fileErrors   = 0;
  int doneErrors   = 0;
  int outErrors    = 0;
  int errorErrors  = 0;
  int assertErrors = 0;
  int cycleCount   = 0;
  int cycleLimit   = 0;                              // Set once the table is loaded

  heapMemory heapMemory_i (
    .clock   (clock),
    .resetN  (resetN),
    .request (request),
    .action  (action),
    .array   (array),
    .index   (index),
    .in      (in),
    .done    (done),
    .out     (out),
    .error   (error)
  );

  bind heapMemory heapMemoryAssertions heapMemoryAssertions_i (
    .clock   (clock),
    .resetN  (resetN),
    .request (request),
    .done    (done),
    .out     (out),
    .error   (error)
  );

  initial begin : clockGen
    clock = 1'b0;
    forever #4 clock = ~clock;                       // Period 8
  end

  // Lines starting with # are comments, blank lines are skipped
  task automatic loadTests();
    int                  fd;
    int                  fields;
    string               line;
    string               name;
    int                  act;
    int                  arr;
    int                  idx;
    int                  expErr;
    logic [DataBits-1:0] inVal;
    logic [DataBits-1:0] expOut;
    fd = $fopen(InputFile, "r");
    if (fd == 0) begin
      $display("Could not open the request file %s", InputFile);
      fileErrors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#" && testCount < MaxTests) begin
          fields = $sscanf(line, "%s %d %d %d %h %h %d",
                           name, act, arr, idx, inVal, expOut, expErr);
          if (fields == 7) begin
            testName[testCount]   = name;
            testAction[testCount] = act[7:0];
            testArray[testCount]  = arr[AddressBits-1:0];
            testIndex[testCount]  = idx[IndexBits-1:0];
            testIn[testCount]     = inVal;
            testOut[testCount]    = expOut;
            testError[testCount]  = expErr[3:0];
            testCount++;
          end
        end
      end
      $fclose(fd);
      if (testCount == 0) begin
        $display("The request file %s holds no usable request line", InputFile);
        fileErrors++;
      end
    end
  endtask

  // One request every two cycles, checked at the negedge after done rises
  task automatic runTest(input int n);
    @(posedge clock);
    request <= 1'b1;
    action  <= action_t'(testAction[n]);
    array   <= testArray[n];
    index   <= testIndex[n];
    in      <= testIn[n];
    @(posedge clock);
    request <= 1'b0;
    @(negedge clock);                                // Done is due one cycle later
    if (!done) begin
      $display("Request %s did not raise done one cycle after the request", testName[n]);
      doneErrors++;
    end else begin
      if (out !== testOut[n]) begin
        $display("Error %s: out expected %h, actual %h", testName[n], testOut[n], out);
        outErrors++;
      end
      if (error !== testError[n]) begin
        $display("Error %s: error expected %0d, actual %0d", testName[n],
                 testError[n], error);
        errorErrors++;
      end
    end
  endtask

  //----------------------------------------------------------------------
  // Watchdog
  //----------------------------------------------------------------------
  initial begin : watchdog
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Run stopped after %0d cycles without finishing the requests", cycleCount);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : stimulus
    resetN  = 1'b0;
    request = 1'b0;
    action  = actClear;
    array   = '0;
    index   = '0;
    in      = '0;
    loadTests();
    cycleLimit = 4 * testCount + 50;                  // Two cycles per request plus margin
    repeat (8) @(posedge clock);
    resetN <= 1'b1;
    for (int n = 0; n < testCount; n++) runTest(n);
    @(posedge clock);
    assertErrors = heapMemory_i.heapMemoryAssertions_i.assertFailures;
    $display("Error counts: file %0d, done %0d, out %0d, error %0d, assertion %0d",
             fileErrors, doneErrors, outErrors, errorErrors, assertErrors);
    if (fileErrors + doneErrors + outErrors + errorErrors + assertErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- verification/heapMemory_assertions.sv
/*
  Bound assertions for the array heap top level
  Done timing, out held on refused requests, done quiet in reset
*/
module heapMemoryAssertions (
  input logic                         clock,
  input logic                         resetN,
  input logic                         request,
  input logic                         done,
  input logic [heapPkg::DataBits-1:0] out,
  input heapPkg::heapError_t          error
);
  import heapPkg::*;

  int assertFailures = 0;                            // Failed assertions so far

  doneFollowsRequest: assert property (
    @(posedge clock) disable iff (!resetN) done == $past(request)   // Exactly one cycle
  ) else begin
    $error("done is not request delayed by one cycle");
    assertFailures++;
  end

  outHeldOnError: assert property (
    @(posedge clock) disable iff (!resetN) (done && error != errNone) |-> $stable(out)
  ) else begin
    $error("out changed on a done that carried an error");
    assertFailures++;
  end

  doneLowInReset: assert property (
    @(posedge clock) !resetN |-> !done                             // Not disabled by reset
  ) else begin
    $error("done was high while reset was asserted");
    assertFailures++;
  end

endmodule

//--- hdl/heapMemory.sv
/*
  Array heap top level
  Array table decides legality, element store holds the data
*/
module heapMemory (
  input  logic                            clock,
  input  logic                            resetN,
  input  logic                            request,     // One cycle strobe
  input  heapPkg::action_t                action,
  input  logic [heapPkg::AddressBits-1:0] array,
  input  logic [heapPkg::IndexBits-1:0]   index,
  input  logic [heapPkg::DataBits-1:0]    in,
  output logic                            done,        // Pulse a cycle later
  output logic [heapPkg::DataBits-1:0]    out,
  output heapPkg::heapError_t             error
);
  import heapPkg::*;

  logic                   accept;                     // Table to store
  logic [AddressBits-1:0] slotArray;
  logic [IndexBits-1:0]   slotIndex;
  logic [SizeBits-1:0]    sizeValue;

  arrayTable arrayTable_i (
    .clock     (clock),
    .resetN    (resetN),
    .request   (request),
    .action    (action),
    .array     (array),
    .index     (index),
    .in        (in),
    .accept    (accept),
    .slotArray (slotArray),
    .slotIndex (slotIndex),
    .sizeValue (sizeValue),
    .done      (done),
    .error     (error)
  );

  elementStore elementStore_i (
    .clock     (clock),
    .resetN    (resetN),
    .accept    (accept),
    .action    (action),
    .in        (in),
    .slotArray (slotArray),
    .slotIndex (slotIndex),
    .sizeValue (sizeValue),
    .out       (out)
  );

endmodule

//--- hdl/elementStore.sv
/*
  Element store of the heap
  Element memory with in-place arithmetic and the registered data output
*/
module elementStore (
  input  logic                            clock,
  input  logic                            resetN,
  input  logic                            accept,      // Legal request this cycle
  input  heapPkg::action_t                action,
  input  logic [heapPkg::DataBits-1:0]    in,
  input  logic [heapPkg::AddressBits-1:0] slotArray,
  input  logic [heapPkg::IndexBits-1:0]   slotIndex,
  input  logic [heapPkg::SizeBits-1:0]    sizeValue,
  output logic [heapPkg::DataBits-1:0]    out
);
  import heapPkg::*;

  logic [DataBits-1:0] mem [ArrayCount][ArrayLength]; // Fixed blocks per array

  logic [DataBits-1:0] word;                          // Addressed element
  logic [DataBits-1:0] newWord;                       // Value written back
  logic [DataBits-1:0] result;                        // Value for out
  logic                writeWord;
  logic                returnsValue;

  //----------------------------------------------------------------------
  // Element arithmetic
  //----------------------------------------------------------------------
  always_comb begin
    word         = mem[slotArray][slotIndex];
    newWord      = word;
    writeWord    = 1'b0;
    returnsValue = 1'b0;
    case (action)
      actWrite: begin
        newWord      = in;
        writeWord    = 1'b1;
        returnsValue = 1'b1;
      end
      actPush: begin
        newWord   = in;
        writeWord = 1'b1;                             // Push is silent on out
      end
      actAdd: begin
        newWord      = word + in;                     // Wraps at DataBits
        writeWord    = 1'b1;
        returnsValue = 1'b1;
      end
      actSubtract: begin
        newWord      = word - in;
        writeWord    = 1'b1;
        returnsValue = 1'b1;
      end
      actOr: begin
        newWord      = word | in;
        writeWord    = 1'b1;
        returnsValue = 1'b1;
      end
      actXor: begin
        newWord      = word ^ in;
        writeWord    = 1'b1;
        returnsValue = 1'b1;
      end
      actAnd: begin
        newWord      = word & in;
        writeWord    = 1'b1;
        returnsValue = 1'b1;
      end
      actRead, actPop, actSize, actAlloc: begin
        returnsValue = 1'b1;                          // Read only
      end
      default: ;
    endcase

    case (action)
      actSize:         result = {{(DataBits-SizeBits){1'b0}}, sizeValue};
      actAlloc:        result = {{(DataBits-AddressBits){1'b0}}, slotArray};
      default:         result = newWord;              // New or unchanged word
    endcase
  end

  //----------------------------------------------------------------------
  // Memory and output register
  //----------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < ArrayCount; a++) begin
        for (int i = 0; i < ArrayLength; i++) mem[a][i] <= '0;  // Start zeroed
      end
    end else if (accept && writeWord) begin
      mem[slotArray][slotIndex] <= newWord;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      out <= '0;
    end else if (accept && returnsValue) begin
      out <= result;                                  // Same edge as done
    end
  end

endmodule

//--- hdl/arrayTable.sv
/*
  Array table of the heap
  Holds sizes, allocation flags and the free stack, checks each request
  and resolves the element slot for the element store
*/
module arrayTable (
  input  logic                            clock,
  input  logic                            resetN,
  input  logic                            request,     // One cycle strobe
  input  heapPkg::action_t                action,
  input  logic [heapPkg::AddressBits-1:0] array,
  input  logic [heapPkg::IndexBits-1:0]   index,
  input  logic [heapPkg::DataBits-1:0]    in,
  output logic                            accept,      // Legal and touches elements
  output logic [heapPkg::AddressBits-1:0] slotArray,
  output logic [heapPkg::IndexBits-1:0]   slotIndex,
  output logic [heapPkg::SizeBits-1:0]    sizeValue,   // Size before the request
  output logic                            done,
  output heapPkg::heapError_t             error
);
  import heapPkg::*;

  //----------------------------------------------------------------------
  // State
  //----------------------------------------------------------------------
  logic [SizeBits-1:0]    sizes [ArrayCount];         // Current size per array
  logic [ArrayCount-1:0]  allocated;                  // Set while handed out
  logic [AddressBits:0]   freshCount;                 // Numbers handed out so far
  logic [AddressBits-1:0] freeStack [ArrayCount];     // Freed array numbers
  logic [AddressBits:0]   freeTop;                    // Entries on the free stack

  //----------------------------------------------------------------------
  // Request decode
  //----------------------------------------------------------------------
  logic                   handedOut;                  // Below fresh count
  heapError_t             accessError;                // Allocation check only
  logic [SizeBits-1:0]    curSize;
  logic [SizeBits-1:0]    sizeMinusOne;
  logic                   inBounds;
  logic                   reuseFreed;                 // Free stack not empty
  logic                   freshLeft;                  // Fresh numbers remain
  logic [AddressBits:0]   topMinusOne;
  logic [AddressBits-1:0] allocNumber;                // Array Alloc hands out
  heapError_t             checkError;
  logic                   touches;                    // Needs the element store
  logic                   legal;

  always_comb begin
    handedOut    = {1'b0, array} < freshCount;
    curSize      = sizes[array];
    sizeMinusOne = curSize - 1'b1;
    inBounds     = {1'b0, index} < curSize;
    reuseFreed   = freeTop != '0;
    freshLeft    = !freshCount[AddressBits];          // Count stops at ArrayCount
    topMinusOne  = freeTop - 1'b1;
    allocNumber  = reuseFreed ? freeStack[topMinusOne[AddressBits-1:0]]
                              : freshCount[AddressBits-1:0];

    if (!handedOut)              accessError = errNotAllocated;
    else if (!allocated[array])  accessError = errFreed;
    else                         accessError = errNone;

    checkError = accessError;                         // Most actions start here
    touches    = 1'b0;
    slotArray  = array;
    slotIndex  = index;

    case (action)
      actClear: begin
        checkError = errNone;
      end
      actWrite, actSize: begin
        touches = 1'b1;
      end
      actRead, actAdd, actSubtract, actOr, actXor, actAnd: begin
        touches = 1'b1;
        if (accessError == errNone && !inBounds) checkError = errOutOfBounds;
      end
      actPush: begin
        touches   = 1'b1;
        slotIndex = curSize[IndexBits-1:0];           // Next free slot
        if (accessError == errNone && curSize[IndexBits]) checkError = errFull;
      end
      actPop: begin
        touches   = 1'b1;
        slotIndex = sizeMinusOne[IndexBits-1:0];      // Last used slot
        if (accessError == errNone && curSize == '0) checkError = errEmpty;
      end
      actResize: begin
        if (accessError == errNone && in > DataBits'(ArrayLength)) begin
          checkError = errTooLarge;
        end
      end
      actAlloc: begin
        touches    = 1'b1;
        slotArray  = allocNumber;
        checkError = (reuseFreed || freshLeft) ? errNone : errOutOfMemory;
      end
      actFree: begin
        touches = 1'b0;                               // Table only
      end
      default: begin
        checkError = errBadAction;
      end
    endcase

    legal  = request && checkError == errNone;
    accept = legal && touches;
  end

  assign sizeValue = curSize;

  //----------------------------------------------------------------------
  // Control registers
  //----------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done       <= 1'b0;
      error      <= errNone;
      freshCount <= '0;
      freeTop    <= '0;
      allocated  <= '0;
      for (int i = 0; i < ArrayCount; i++) sizes[i] <= '0;
    end else begin
      done <= request;                                // Fixed one cycle latency
      if (request) error <= checkError;               // Held until next done
      if (legal) begin
        case (action)
          actClear: begin
            freshCount <= '0;
            freeTop    <= '0;
            allocated  <= '0;
            for (int i = 0; i < ArrayCount; i++) sizes[i] <= '0;
          end
          actWrite: begin
            if ({1'b0, index} >= curSize) sizes[array] <= {1'b0, index} + 1'b1;
          end
          actPush:   sizes[array] <= curSize + 1'b1;
          actPop:    sizes[array] <= sizeMinusOne;
          actResize: sizes[array] <= in[SizeBits-1:0];  // Range checked above
          actAlloc: begin
            allocated[allocNumber] <= 1'b1;
            sizes[allocNumber]     <= '0;             // Fresh array is empty
            if (reuseFreed) freeTop    <= topMinusOne; // Latest freed first
            else            freshCount <= freshCount + 1'b1;
          end
          actFree: begin
            allocated[array] <= 1'b0;
            freeTop          <= freeTop + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Free stack contents, only meaningful below freeTop
  always_ff @(posedge clock) begin
    if (legal && action == actFree) freeStack[freeTop[AddressBits-1:0]] <= array;
  end

endmodule

//--- hdl/heapPkg.sv
/*
  Array heap shared definitions
  Widths, request action codes and the error codes reported on done
*/
package heapPkg;

  //----------------------------------------------------------------------
  // Geometry
  //----------------------------------------------------------------------
  localparam int AddressBits = 3;                     // Bits in an array number
  localparam int IndexBits   = 3;                     // Bits in an element index
  localparam int DataBits    = 16;                    // Element width
  localparam int ArrayCount  = 1 << AddressBits;      // Arrays in the heap
  localparam int ArrayLength = 1 << IndexBits;        // Elements per array
  localparam int SizeBits    = IndexBits + 1;         // Size can reach ArrayLength

  //----------------------------------------------------------------------
  // Request actions, codes kept from the host protocol
  //----------------------------------------------------------------------
  typedef enum logic [7:0] {
    actClear    = 8'd1,                               // Drop all allocations
    actWrite    = 8'd2,                               // Store an element, grow size
    actRead     = 8'd3,                               // Fetch an element
    actSize     = 8'd4,                               // Report array size
    actPush     = 8'd14,                              // Append at current size
    actPop      = 8'd15,                              // Remove last element
    actResize   = 8'd17,                              // Set size directly
    actAlloc    = 8'd18,                              // Hand out an array
    actFree     = 8'd19,                              // Return an array
    actAdd      = 8'd20,                              // Element plus in
    actSubtract = 8'd22,                              // Element minus in
    actOr       = 8'd28,                              // Element or in
    actXor      = 8'd29,                              // Element xor in
    actAnd      = 8'd30                               // Element and in
  } action_t;

  //----------------------------------------------------------------------
  // Error codes, valid while done is high
  //----------------------------------------------------------------------
  typedef enum logic [3:0] {
    errNone,                                          // Request completed
    errNotAllocated,                                  // Array number never handed out
    errFreed,                                         // Array handed out, now freed
    errOutOfBounds,                                   // Index at or past size
    errFull,                                          // Push with size at limit
    errEmpty,                                         // Pop with size zero
    errTooLarge,                                      // Resize beyond ArrayLength
    errOutOfMemory,                                   // No fresh or freed array left
    errBadAction                                      // Unknown action code
  } heapError_t;

  // Summary of which actions return a value on out
  //   Write  returns in
  //   Read   returns the element
  //   Size   returns the size
  //   Pop    returns the removed element
  //   Alloc  returns the array number
  //   Add, Subtract, Or, Xor, And return the new element
  // Push, Resize, Free and Clear leave out alone

endpackage
